//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int data_w   = 8;  // data and instruction words
	localparam int addr_w   = 8;  // imem and dmem address
	localparam int opcode_w = 6;  // low bits of the instruction word

	// ----------------------------------------
	// opcodes
	// ----------------------------------------
	localparam logic [opcode_w-1:0] op_ldaci  = 6'd0;   // ac <- operand
	localparam logic [opcode_w-1:0] op_mvacr1 = 6'd8;
	localparam logic [opcode_w-1:0] op_mvacr2 = 6'd9;
	localparam logic [opcode_w-1:0] op_addr1  = 6'd11;  // sum into ac and r1
	localparam logic [opcode_w-1:0] op_addr2  = 6'd12;  // sum into ac and r2
	localparam logic [opcode_w-1:0] op_staci  = 6'd13;  // mem[operand] <- ac
	localparam logic [opcode_w-1:0] op_mult   = 6'd15;
	localparam logic [opcode_w-1:0] op_sub    = 6'd19;
	localparam logic [opcode_w-1:0] op_clrac  = 6'd24;
	localparam logic [opcode_w-1:0] op_incac  = 6'd26;
	localparam logic [opcode_w-1:0] op_jpnz   = 6'd27;  // jump when ac != 0
	localparam logic [opcode_w-1:0] op_endop  = 6'd28;  // halt

	// ----------------------------------------
	// execute operations
	// ----------------------------------------
	typedef enum logic [3:0] {
		exec_load,    // ac takes the operand
		exec_mv_r1,
		exec_mv_r2,
		exec_add_r1,  // ac + r1 into both
		exec_add_r2,  // ac + r2 into both
		exec_sub,     // ac - r1
		exec_mul,     // low byte of ac * r1
		exec_clr,
		exec_inc
	} exec_op_t;

	// ----------------------------------------
	// sequencer states
	// ----------------------------------------
	typedef enum logic [2:0] {
		st_fetch_op,   // start opcode fetch
		st_wait_op,    // wait for opcode word
		st_decode,
		st_fetch_arg,  // start operand fetch
		st_wait_arg,   // wait for operand word
		st_exec,
		st_halt
	} seq_state_t;

endpackage

`default_nettype wire

//--- verilog/instr_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module instr_fetch
(
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          fetch_start,
	input  wire                          jump_en,
	input  wire [cpu_pkg::addr_w-1:0]    jump_addr,
	input  wire                          imem_ack,
	input  wire [cpu_pkg::data_w-1:0]    imem_data,
	output logic                         fetch_done,
	output logic [cpu_pkg::data_w-1:0]   fetch_word,
	output logic                         imem_req,
	output logic [cpu_pkg::addr_w-1:0]   imem_addr
);

	typedef enum logic [1:0] {
		ph_idle,
		ph_req,      // req high, memory not yet acked
		ph_ack_low,  // req dropped, waiting for ack release
		ph_done      // word handed to the sequencer
	} phase_t;

	phase_t                      phase;
	logic [cpu_pkg::addr_w-1:0]  pc;

	// ----------------------------------------
	// four-phase handshake
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
			phase <= ph_idle;
		else
		begin
			case (phase)
				ph_idle:
				begin
					if (fetch_start)
						phase <= ph_req;
				end
				ph_req:
				begin
					if (imem_ack)
						phase <= ph_ack_low;
				end
				ph_ack_low:
				begin
					if (!imem_ack)
						phase <= ph_done;
				end
				default:
					phase <= ph_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (phase == ph_req && imem_ack)
			fetch_word <= imem_data;  // data valid with ack
	end

	// pc steps after each fetch, jump overrides
	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= '0;
		else if (jump_en)
			pc <= jump_addr;
		else if (fetch_done)
			pc <= pc + 1'b1;
	end

	assign imem_req   = (phase == ph_req);
	assign fetch_done = (phase == ph_done);
	assign imem_addr  = pc;  // stable for the whole request

endmodule

`default_nettype wire

//--- verilog/decode_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module decode_sequencer
(
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          fetch_done,
	input  wire [cpu_pkg::data_w-1:0]    fetch_word,
	input  wire                          zero,
	output logic                         fetch_start,
	output logic                         jump_en,
	output logic                         exec_en,
	output cpu_pkg::exec_op_t            exec_op,
	output logic [cpu_pkg::data_w-1:0]   operand,
	output logic                         store_en,
	output logic                         halt_en
);

	cpu_pkg::seq_state_t            state;
	logic [cpu_pkg::opcode_w-1:0]   opcode;     // instruction register
	logic                           needs_arg;
	logic                           is_alu;

	// ----------------------------------------
	// opcode decode
	// ----------------------------------------
	assign needs_arg = opcode inside {cpu_pkg::op_ldaci, cpu_pkg::op_staci, cpu_pkg::op_jpnz};

	always_comb
	begin
		is_alu  = 1'b1;
		exec_op = cpu_pkg::exec_load;
		case (opcode)
			cpu_pkg::op_ldaci:  exec_op = cpu_pkg::exec_load;
			cpu_pkg::op_mvacr1: exec_op = cpu_pkg::exec_mv_r1;
			cpu_pkg::op_mvacr2: exec_op = cpu_pkg::exec_mv_r2;
			cpu_pkg::op_addr1:  exec_op = cpu_pkg::exec_add_r1;
			cpu_pkg::op_addr2:  exec_op = cpu_pkg::exec_add_r2;
			cpu_pkg::op_mult:   exec_op = cpu_pkg::exec_mul;
			cpu_pkg::op_sub:    exec_op = cpu_pkg::exec_sub;
			cpu_pkg::op_clrac:  exec_op = cpu_pkg::exec_clr;
			cpu_pkg::op_incac:  exec_op = cpu_pkg::exec_inc;
			default:            is_alu = 1'b0;  // staci, jpnz, endop, no-ops
		endcase
	end

	// ----------------------------------------
	// control FSM
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state       <= cpu_pkg::st_fetch_op;
			fetch_start <= 1'b0;
		end
		else
		begin
			fetch_start <= 1'b0;
			case (state)
				cpu_pkg::st_fetch_op:
				begin
					fetch_start <= 1'b1;
					state       <= cpu_pkg::st_wait_op;
				end
				cpu_pkg::st_wait_op:
				begin
					if (fetch_done)
						state <= cpu_pkg::st_decode;
				end
				cpu_pkg::st_decode:
				begin
					if (opcode == cpu_pkg::op_endop)
						state <= cpu_pkg::st_halt;
					else if (needs_arg)
						state <= cpu_pkg::st_fetch_arg;
					else if (is_alu)
						state <= cpu_pkg::st_exec;
					else
						state <= cpu_pkg::st_fetch_op;  // unknown opcode, no-op
				end
				cpu_pkg::st_fetch_arg:
				begin
					fetch_start <= 1'b1;
					state       <= cpu_pkg::st_wait_arg;
				end
				cpu_pkg::st_wait_arg:
				begin
					if (fetch_done)
						state <= cpu_pkg::st_exec;
				end
				cpu_pkg::st_exec:
					state <= cpu_pkg::st_fetch_op;
				cpu_pkg::st_halt:
					state <= cpu_pkg::st_halt;  // no more fetches
				default:
					state <= cpu_pkg::st_fetch_op;
			endcase
		end
	end

	// instruction and operand capture
	always_ff @(posedge clk)
	begin
		if (state == cpu_pkg::st_wait_op && fetch_done)
			opcode <= fetch_word[cpu_pkg::opcode_w-1:0];
		if (state == cpu_pkg::st_wait_arg && fetch_done)
			operand <= fetch_word;
	end

	// one-cycle strobes
	assign exec_en  = (state == cpu_pkg::st_exec) && is_alu;
	assign store_en = (state == cpu_pkg::st_exec) && (opcode == cpu_pkg::op_staci);
	assign jump_en  = (state == cpu_pkg::st_exec) && (opcode == cpu_pkg::op_jpnz) && !zero;
	assign halt_en  = (state == cpu_pkg::st_decode) && (opcode == cpu_pkg::op_endop);

endmodule

`default_nettype wire

//--- verilog/execute_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module execute_datapath
(
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          exec_en,
	input  wire cpu_pkg::exec_op_t       exec_op,
	input  wire [cpu_pkg::data_w-1:0]    operand,
	output logic [cpu_pkg::data_w-1:0]   ac,
	output logic                         zero
);

	logic [cpu_pkg::data_w-1:0]  r1;
	logic [cpu_pkg::data_w-1:0]  r2;
	logic [cpu_pkg::data_w-1:0]  ac_nxt;
	logic [cpu_pkg::data_w-1:0]  r1_nxt;
	logic [cpu_pkg::data_w-1:0]  r2_nxt;

	// ----------------------------------------
	// alu, all modulo 2**data_w
	// ----------------------------------------
	always_comb
	begin
		ac_nxt = ac;
		r1_nxt = r1;
		r2_nxt = r2;
		case (exec_op)
			cpu_pkg::exec_load:  ac_nxt = operand;
			cpu_pkg::exec_mv_r1: r1_nxt = ac;
			cpu_pkg::exec_mv_r2: r2_nxt = ac;
			cpu_pkg::exec_add_r1:
			begin
				ac_nxt = ac + r1;
				r1_nxt = ac + r1;  // sum written back to r1
			end
			cpu_pkg::exec_add_r2:
			begin
				ac_nxt = ac + r2;
				r2_nxt = ac + r2;
			end
			cpu_pkg::exec_sub:   ac_nxt = ac - r1;    // wraps below zero
			cpu_pkg::exec_mul:   ac_nxt = ac * r1;    // low byte of product
			cpu_pkg::exec_clr:   ac_nxt = '0;
			cpu_pkg::exec_inc:   ac_nxt = ac + 1'b1;
			default:             ac_nxt = ac;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ac   <= '0;
			r1   <= '0;
			r2   <= '0;
			zero <= 1'b1;  // ac cleared
		end
		else if (exec_en)
		begin
			ac   <= ac_nxt;
			r1   <= r1_nxt;
			r2   <= r2_nxt;
			zero <= (ac_nxt == '0);
		end
	end

endmodule

`default_nettype wire

//--- verilog/store_port.sv
`timescale 1ns/100ps
`default_nettype none

module store_port
(
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          store_en,
	input  wire [cpu_pkg::data_w-1:0]    operand,
	input  wire [cpu_pkg::data_w-1:0]    ac,
	input  wire                          halt_en,
	output logic                         dmem_wr,
	output logic [cpu_pkg::addr_w-1:0]   dmem_addr,
	output logic [cpu_pkg::data_w-1:0]   dmem_wdata,
	output logic                         end_op
);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			dmem_wr <= 1'b0;
			end_op  <= 1'b0;
		end
		else
		begin
			dmem_wr <= store_en;  // one-cycle strobe, one cycle late
			if (halt_en)
				end_op <= 1'b1;   // held until reset
		end
	end

	always_ff @(posedge clk)
	begin
		if (store_en)
		begin
			dmem_addr  <= operand[cpu_pkg::addr_w-1:0];
			dmem_wdata <= ac;
		end
	end

endmodule

`default_nettype wire

//--- verilog/acc_cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module acc_cpu_top
(
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          imem_ack,
	input  wire [cpu_pkg::data_w-1:0]    imem_data,
	output logic                         imem_req,
	output logic [cpu_pkg::addr_w-1:0]   imem_addr,
	output logic                         dmem_wr,
	output logic [cpu_pkg::addr_w-1:0]   dmem_addr,
	output logic [cpu_pkg::data_w-1:0]   dmem_wdata,
	output logic                         end_op
);

	// ----------------------------------------
	// internal control and data
	// ----------------------------------------
	logic                         fetch_start;
	logic                         fetch_done;
	logic [cpu_pkg::data_w-1:0]   fetch_word;
	logic                         jump_en;
	logic                         exec_en;
	cpu_pkg::exec_op_t            exec_op;
	logic [cpu_pkg::data_w-1:0]   operand;
	logic                         store_en;
	logic                         halt_en;
	logic [cpu_pkg::data_w-1:0]   ac;
	logic                         zero;

	instr_fetch u_fetch (
		.clk         (clk),
		.rst         (rst),
		.fetch_start (fetch_start),
		.jump_en     (jump_en),
		.jump_addr   (operand[cpu_pkg::addr_w-1:0]),  // jpnz target
		.imem_ack    (imem_ack),
		.imem_data   (imem_data),
		.fetch_done  (fetch_done),
		.fetch_word  (fetch_word),
		.imem_req    (imem_req),
		.imem_addr   (imem_addr)
	);

	decode_sequencer u_seq (
		.clk         (clk),
		.rst         (rst),
		.fetch_done  (fetch_done),
		.fetch_word  (fetch_word),
		.zero        (zero),
		.fetch_start (fetch_start),
		.jump_en     (jump_en),
		.exec_en     (exec_en),
		.exec_op     (exec_op),
		.operand     (operand),
		.store_en    (store_en),
		.halt_en     (halt_en)
	);

	execute_datapath u_dp (
		.clk     (clk),
		.rst     (rst),
		.exec_en (exec_en),
		.exec_op (exec_op),
		.operand (operand),
		.ac      (ac),
		.zero    (zero)
	);

	store_port u_store (
		.clk        (clk),
		.rst        (rst),
		.store_en   (store_en),
		.operand    (operand),
		.ac         (ac),
		.halt_en    (halt_en),
		.dmem_wr    (dmem_wr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.end_op     (end_op)
	);

endmodule

`default_nettype wire

//--- dv/acc_cpu_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module acc_cpu_asserts
(
	input wire                          clk,
	input wire                          rst,
	input wire                          imem_req,
	input wire                          imem_ack,
	input wire [cpu_pkg::addr_w-1:0]    imem_addr,
	input wire                          fetch_done
);

	int fail_count = 0;  // read by the testbench

	// address held for the whole request
	addr_stable: assert property (@(posedge clk) disable iff (rst)
		imem_req |=> (!imem_req || $stable(imem_addr)))
	else
	begin
		$error("imem_addr changed while imem_req was high");
		fail_count++;
	end

	// new request only after the memory released ack
	req_after_ack: assert property (@(posedge clk) disable iff (rst)
		(imem_ack && !imem_req) |=> !imem_req)
	else
	begin
		$error("imem_req rose while imem_ack was still high");
		fail_count++;
	end

	done_single: assert property (@(posedge clk) disable iff (rst)
		fetch_done |=> !fetch_done)
	else
	begin
		$error("fetch_done high in two consecutive cycles");
		fail_count++;
	end

endmodule

`default_nettype wire

//--- dv/tb_acc_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_acc_cpu;

	logic                        clk;
	logic                        rst;
	logic                        imem_ack;
	logic [cpu_pkg::data_w-1:0]  imem_data;
	logic                        imem_req;
	logic [cpu_pkg::addr_w-1:0]  imem_addr;
	logic                        dmem_wr;
	logic [cpu_pkg::addr_w-1:0]  dmem_addr;
	logic [cpu_pkg::data_w-1:0]  dmem_wdata;
	logic                        end_op;

	logic [cpu_pkg::data_w-1:0]  prog [0:255];  // instruction memory image
	int                          wptr;          // next free program word
	int                          ack_wait;      // -1 when no delay is counting
	logic [31:0]                 lfsr;
	logic [7:0]                  got_addr [$];
	logic [7:0]                  got_data [$];
	logic [7:0]                  exp_addr [$];
	logic [7:0]                  exp_data [$];

	acc_cpu_top dut (
		.clk        (clk),
		.rst        (rst),
		.imem_ack   (imem_ack),
		.imem_data  (imem_data),
		.imem_req   (imem_req),
		.imem_addr  (imem_addr),
		.dmem_wr    (dmem_wr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.end_op     (end_op)
	);

	bind instr_fetch acc_cpu_asserts u_asserts (
		.clk        (clk),
		.rst        (rst),
		.imem_req   (imem_req),
		.imem_ack   (imem_ack),
		.imem_addr  (imem_addr),
		.fetch_done (fetch_done)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic int draw_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);  // one step per bit
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	// ----------------------------------------
	// instruction memory and store monitor
	// ----------------------------------------
	always @(posedge clk)
	begin
		#1;
		if (imem_req && !imem_ack)
		begin
			if (ack_wait < 0)
				ack_wait = draw_bits(2);  // 0 to 3 cycles of delay
			if (ack_wait == 0)
			begin
				imem_data = prog[imem_addr];
				imem_ack  = 1'b1;
				ack_wait  = -1;
			end
			else
				ack_wait--;
		end
		else if (!imem_req && imem_ack)
		begin
			if (ack_wait < 0)
				ack_wait = draw_bits(2);  // 0 to 3 cycles before release
			if (ack_wait == 0)
			begin
				imem_ack = 1'b0;  // last phase of the handshake
				ack_wait = -1;
			end
			else
				ack_wait--;
		end
	end

	always @(negedge clk)
	begin
		if (!rst && dmem_wr)
		begin
			got_addr.push_back(dmem_addr);
			got_data.push_back(dmem_wdata);
		end
	end

	task automatic compare_value(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		assert (got === exp)
		else
		begin
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic require_true(input logic cond, input string what);
		assert (cond)
		else
		begin
			$display("%s", what);
			$display("TEST FAILED");
			$fatal(1, "check failed");
		end
	endtask

	// bound handshake checks feed the verdict
	always @(negedge clk)
	begin
		require_true(dut.u_fetch.u_asserts.fail_count == 0,
			"a bound assertion on the fetch handshake failed");
	end

	// ----------------------------------------
	// program building and running
	// ----------------------------------------
	task automatic new_program();
		for (int a = 0; a < 256; a++)
			prog[a] = 8'(cpu_pkg::op_endop);  // stray fetches halt
		wptr = 0;
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic emit(input logic [cpu_pkg::opcode_w-1:0] op);
		prog[wptr] = 8'(op);
		wptr++;
	endtask

	task automatic emit_arg(input logic [cpu_pkg::opcode_w-1:0] op, input logic [7:0] arg);
		emit(op);
		prog[wptr] = arg;
		wptr++;
	endtask

	task automatic expect_store(input logic [7:0] addr, input logic [7:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic reset_cpu();
		@(posedge clk);
		#1;
		rst = 1'b1;
		got_addr.delete();
		got_data.delete();
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	task automatic run_to_halt();
		int cycles;
		reset_cpu();
		cycles = 0;
		while (!end_op && cycles < 4000)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		require_true(end_op, "timeout while waiting for end_op");
	endtask

	task automatic match_stores();
		require_true(got_data.size() == exp_data.size(),
			$sformatf("expected %0d stores but saw %0d", exp_data.size(), got_data.size()));
		foreach (exp_data[i])
		begin
			compare_value("dmem_addr", got_addr[i], exp_addr[i]);
			compare_value("dmem_wdata", got_data[i], exp_data[i]);
		end
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic add_and_move();
		new_program();
		emit_arg(cpu_pkg::op_ldaci, 8'hc8);
		emit(cpu_pkg::op_mvacr1);              // r1 = 0xc8
		emit_arg(cpu_pkg::op_ldaci, 8'h5a);
		emit(cpu_pkg::op_addr1);               // sum into ac and r1
		emit_arg(cpu_pkg::op_staci, 8'h10);
		emit(cpu_pkg::op_clrac);
		emit(cpu_pkg::op_addr1);               // 0 + r1 reads r1 back
		emit_arg(cpu_pkg::op_staci, 8'h11);
		emit_arg(cpu_pkg::op_ldaci, 8'h9b);
		emit(cpu_pkg::op_mvacr2);
		emit(cpu_pkg::op_addr2);
		emit_arg(cpu_pkg::op_staci, 8'h12);
		emit(cpu_pkg::op_endop);
		expect_store(8'h10, 8'((8'hc8 + 8'h5a) % 256));
		expect_store(8'h11, 8'((8'hc8 + 8'h5a) % 256));
		expect_store(8'h12, 8'((2 * 8'h9b) % 256));
		run_to_halt();
		match_stores();
	endtask

	task automatic sub_and_mult();
		new_program();
		emit_arg(cpu_pkg::op_ldaci, 8'd5);
		emit(cpu_pkg::op_mvacr1);
		emit_arg(cpu_pkg::op_ldaci, 8'd3);
		emit(cpu_pkg::op_sub);                 // 3 - 5 wraps
		emit_arg(cpu_pkg::op_staci, 8'h20);
		emit_arg(cpu_pkg::op_ldaci, 8'd23);
		emit(cpu_pkg::op_mvacr1);
		emit_arg(cpu_pkg::op_ldaci, 8'd45);
		emit(cpu_pkg::op_mult);                // product above 255
		emit_arg(cpu_pkg::op_staci, 8'h21);
		emit(cpu_pkg::op_endop);
		expect_store(8'h20, 8'((3 - 5 + 256) % 256));
		expect_store(8'h21, 8'((23 * 45) % 256));
		run_to_halt();
		match_stores();
	endtask

	task automatic jpnz_loop();
		int loop_at;
		int v;
		new_program();
		emit_arg(cpu_pkg::op_ldaci, 8'd1);
		emit(cpu_pkg::op_mvacr1);              // loop step
		emit_arg(cpu_pkg::op_ldaci, 8'd3);
		loop_at = wptr;
		emit(cpu_pkg::op_sub);
		emit_arg(cpu_pkg::op_staci, 8'h30);
		emit_arg(cpu_pkg::op_jpnz, 8'(loop_at));
		emit(cpu_pkg::op_endop);
		v = 3;
		while (v != 0)
		begin
			v = (v - 1 + 256) % 256;
			expect_store(8'h30, 8'(v));
		end
		run_to_halt();
		match_stores();
	endtask

	task automatic clear_inc_noop();
		new_program();
		emit_arg(cpu_pkg::op_ldaci, 8'h77);
		emit(cpu_pkg::op_clrac);
		emit(6'd50);                           // unused opcode
		emit(cpu_pkg::op_incac);
		emit(6'd63);
		emit_arg(cpu_pkg::op_staci, 8'h40);
		emit(cpu_pkg::op_endop);
		expect_store(8'h40, 8'h01);
		run_to_halt();
		match_stores();
	endtask

	task automatic halt_hold();
		new_program();
		emit_arg(cpu_pkg::op_ldaci, 8'h09);
		emit_arg(cpu_pkg::op_staci, 8'h50);
		emit(cpu_pkg::op_endop);
		emit_arg(cpu_pkg::op_ldaci, 8'h66);   // past the halt
		emit_arg(cpu_pkg::op_staci, 8'h51);
		expect_store(8'h50, 8'h09);
		run_to_halt();
		for (int i = 0; i < 20; i++)
		begin
			@(posedge clk);
			#1;
			compare_value("end_op", end_op, 8'h01);
			compare_value("imem_req", imem_req, 8'h00);
		end
		match_stores();
	endtask

	initial
	begin
		lfsr      = 32'hb9c0;
		clk       = 1'b0;
		rst       = 1'b1;
		imem_ack  = 1'b0;
		imem_data = '0;
		ack_wait  = -1;
		wptr      = 0;
		add_and_move();
		sub_and_mult();
		jpnz_loop();
		clear_inc_noop();
		halt_hold();
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
verilog/cpu_pkg.sv
verilog/instr_fetch.sv
verilog/decode_sequencer.sv
verilog/execute_datapath.sv
verilog/store_port.sv
verilog/acc_cpu_top.sv
dv/acc_cpu_asserts.sv
dv/tb_acc_cpu.sv

//--- Bender.yml
package:
  name: acc_cpu

sources:
  - verilog/cpu_pkg.sv
  - verilog/instr_fetch.sv
  - verilog/decode_sequencer.sv
  - verilog/execute_datapath.sv
  - verilog/store_port.sv
  - verilog/acc_cpu_top.sv
  - target: simulation
    files:
      - dv/acc_cpu_asserts.sv
      - dv/tb_acc_cpu.sv
